// File: hw/ex_pkg.sv
`default_nettype none

package ex_pkg;

    typedef logic signed [31:0] word_t;     // One data word
    typedef logic [4:0]         reg_addr_t; // Register number, r0 is hardwired
    typedef logic [3:0]         alu_ctrl_t; // ALU operation code
    typedef logic [5:0]         opcode_t;
    typedef logic [5:0]         funct_t;

    // ALU operation codes, BEQ and BNE are inverted so zero means taken
    localparam alu_ctrl_t ALU_SLL   = 4'd0;
    localparam alu_ctrl_t ALU_SRL   = 4'd1;
    localparam alu_ctrl_t ALU_SRA   = 4'd2;
    localparam alu_ctrl_t ALU_ADD   = 4'd3;
    localparam alu_ctrl_t ALU_SUB   = 4'd4;
    localparam alu_ctrl_t ALU_AND   = 4'd5;
    localparam alu_ctrl_t ALU_OR    = 4'd6;
    localparam alu_ctrl_t ALU_XOR   = 4'd7;
    localparam alu_ctrl_t ALU_NOR   = 4'd8;
    localparam alu_ctrl_t ALU_SLT   = 4'd9;
    localparam alu_ctrl_t ALU_SLL16 = 4'd10;
    localparam alu_ctrl_t ALU_BEQ   = 4'd11; // A != B
    localparam alu_ctrl_t ALU_BNE   = 4'd12; // A == B

    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_BNE   = 6'h05;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_SLTI  = 6'h0a;
    localparam opcode_t OP_ANDI  = 6'h0c;
    localparam opcode_t OP_ORI   = 6'h0d;
    localparam opcode_t OP_XORI  = 6'h0e;
    localparam opcode_t OP_LUI   = 6'h0f;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;

    localparam funct_t FN_SLL  = 6'h00;
    localparam funct_t FN_SRL  = 6'h02;
    localparam funct_t FN_SRA  = 6'h03;
    localparam funct_t FN_SLLV = 6'h04;
    localparam funct_t FN_SRLV = 6'h06;
    localparam funct_t FN_SRAV = 6'h07;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_NOR  = 6'h27;
    localparam funct_t FN_SLT  = 6'h2a;

    typedef struct packed {
        logic      valid;
        opcode_t   opcode;
        funct_t    funct;
        logic [4:0] shamt;
        word_t     rs_val;
        word_t     rt_val;
        logic [15:0] imm;
        reg_addr_t rs_addr;
        reg_addr_t rt_addr;
        reg_addr_t dest;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        logic      branch;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        word_t     result;
        word_t     store_data;
        reg_addr_t dest;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        logic      branch_taken;
    } ex_mem_t;

    // Write-back seen by the bypass
    typedef struct packed {
        logic      reg_write;
        reg_addr_t dest;
        word_t     value;
    } wb_fwd_t;

endpackage

`default_nettype wire

// File: hw/alu.sv
`default_nettype none

module alu (
    input  var ex_pkg::word_t     i_a,
    input  var ex_pkg::word_t     i_b,
    input  var ex_pkg::alu_ctrl_t i_alu_ctrl, // From alu_control
    output ex_pkg::word_t         o_result,
    output logic                  o_zero
);

    import ex_pkg::*;

    logic [4:0] shift_amt;

    assign shift_amt = i_a[4:0]; // Shifts use only the low five bits

    always_comb begin
        case (i_alu_ctrl)
            ALU_SLL: begin
                o_result = i_b << shift_amt;        // SLL and SLLV
            end
            ALU_SRL: begin
                o_result = i_b >> shift_amt;        // SRL and SRLV
            end
            ALU_SRA: begin
                o_result = i_b >>> shift_amt;       // Sign bit fills in
            end
            ALU_ADD: begin
                o_result = i_a + i_b;
            end
            ALU_SUB: begin
                o_result = i_a - i_b;
            end
            ALU_AND: begin
                o_result = i_a & i_b;
            end
            ALU_OR: begin
                o_result = i_a | i_b;
            end
            ALU_XOR: begin
                o_result = i_a ^ i_b;
            end
            ALU_NOR: begin
                o_result = ~(i_a | i_b);
            end
            ALU_SLT: begin
                o_result = (i_a < i_b) ? 32'sd1 : 32'sd0; // Signed compare
            end
            ALU_SLL16: begin
                o_result = i_b << 16;               // LUI
            end
            ALU_BEQ: begin
                o_result = (i_a != i_b) ? 32'sd1 : 32'sd0; // Zero when equal
            end
            ALU_BNE: begin
                o_result = (i_a == i_b) ? 32'sd1 : 32'sd0; // Zero when not equal
            end
            default: begin
                o_result = '0;
            end
        endcase
    end

    // Branch condition is taken from this flag downstream
    assign o_zero = (o_result == '0);

endmodule

`default_nettype wire

// File: hw/alu_control.sv
`default_nettype none

module alu_control (
    input  var logic [5:0]        i_opcode,
    input  var logic [5:0]        i_funct,
    output ex_pkg::alu_ctrl_t     o_alu_ctrl,
    output logic                  o_use_shamt, // A comes from shamt
    output logic                  o_use_imm,   // B comes from the immediate
    output logic                  o_zero_ext   // Immediate is zero-extended
);

    import ex_pkg::*;

    always_comb begin
        o_alu_ctrl  = ALU_ADD; // Unknown codes fall back to add
        o_use_shamt = 1'b0;
        o_use_imm   = 1'b0;
        o_zero_ext  = 1'b0;

        case (i_opcode)
            OP_RTYPE: begin
                case (i_funct)
                    FN_SLL: begin
                        o_alu_ctrl  = ALU_SLL;
                        o_use_shamt = 1'b1;
                    end
                    FN_SRL: begin
                        o_alu_ctrl  = ALU_SRL;
                        o_use_shamt = 1'b1;
                    end
                    FN_SRA: begin
                        o_alu_ctrl  = ALU_SRA;
                        o_use_shamt = 1'b1;
                    end
                    FN_SLLV: o_alu_ctrl = ALU_SLL; // Amount from rs
                    FN_SRLV: o_alu_ctrl = ALU_SRL;
                    FN_SRAV: o_alu_ctrl = ALU_SRA;
                    FN_ADDU: o_alu_ctrl = ALU_ADD;
                    FN_SUBU: o_alu_ctrl = ALU_SUB;
                    FN_AND:  o_alu_ctrl = ALU_AND;
                    FN_OR:   o_alu_ctrl = ALU_OR;
                    FN_XOR:  o_alu_ctrl = ALU_XOR;
                    FN_NOR:  o_alu_ctrl = ALU_NOR;
                    FN_SLT:  o_alu_ctrl = ALU_SLT;
                    default: o_alu_ctrl = ALU_ADD;
                endcase
            end
            OP_ADDI, OP_ADDIU, OP_LW, OP_SW: begin
                o_alu_ctrl = ALU_ADD; // Address or sum, sign-extended
                o_use_imm  = 1'b1;
            end
            OP_SLTI: begin
                o_alu_ctrl = ALU_SLT;
                o_use_imm  = 1'b1;
            end
            OP_ANDI: begin
                o_alu_ctrl = ALU_AND;
                o_use_imm  = 1'b1;
                o_zero_ext = 1'b1;
            end
            OP_ORI: begin
                o_alu_ctrl = ALU_OR;
                o_use_imm  = 1'b1;
                o_zero_ext = 1'b1;
            end
            OP_XORI: begin
                o_alu_ctrl = ALU_XOR;
                o_use_imm  = 1'b1;
                o_zero_ext = 1'b1;
            end
            OP_LUI: begin
                o_alu_ctrl = ALU_SLL16; // Immediate goes to the upper half
                o_use_imm  = 1'b1;
            end
            // Both branches compare rs against rt
            OP_BEQ: o_alu_ctrl = ALU_BEQ;
            OP_BNE: o_alu_ctrl = ALU_BNE;
            default: begin
                o_alu_ctrl = ALU_ADD;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/ex_operand_sel.sv
`default_nettype none

module ex_operand_sel (
    input  var ex_pkg::id_ex_t  i_id_ex,
    input  var logic            i_use_shamt,
    input  var logic            i_use_imm,
    input  var logic            i_zero_ext,
    input  var ex_pkg::ex_mem_t i_mem_fwd,  // EX/MEM register output
    input  var ex_pkg::wb_fwd_t i_wb_fwd,   // MEM/WB write-back
    output ex_pkg::word_t       o_op_a,
    output ex_pkg::word_t       o_op_b,
    output ex_pkg::word_t       o_store_data
);

    import ex_pkg::*;

    word_t rs_fwd;
    word_t rt_fwd;
    word_t imm_ext;
    word_t shamt_ext;

    // Picks the newest value for one source register
    function automatic word_t bypass(
        input reg_addr_t addr,
        input word_t     id_val,
        input ex_mem_t   mem,
        input wb_fwd_t   wb
    );
        logic  mem_hit;
        logic  wb_hit;
        word_t val;

        // Loads in EX/MEM have no data yet
        mem_hit = mem.valid && mem.reg_write && !mem.mem_read
                  && (mem.dest == addr);
        wb_hit  = wb.reg_write && (wb.dest == addr);

        if (addr == '0) begin
            val = id_val; // r0 is never forwarded
        end else if (mem_hit) begin
            val = mem.result;
        end else if (wb_hit) begin
            val = wb.value;
        end else begin
            val = id_val;
        end
        return val;
    endfunction

    always_comb begin
        rs_fwd = bypass(i_id_ex.rs_addr, i_id_ex.rs_val, i_mem_fwd, i_wb_fwd);
        rt_fwd = bypass(i_id_ex.rt_addr, i_id_ex.rt_val, i_mem_fwd, i_wb_fwd);
    end

    // Logical immediates are zero-extended, the rest sign-extended
    always_comb begin
        if (i_zero_ext) begin
            imm_ext = {16'h0000, i_id_ex.imm};
        end else begin
            imm_ext = {{16{i_id_ex.imm[15]}}, i_id_ex.imm};
        end
    end

    assign shamt_ext = {27'd0, i_id_ex.shamt};

    always_comb begin
        if (i_use_shamt) begin
            o_op_a = shamt_ext; // Fixed shifts
        end else begin
            o_op_a = rs_fwd;
        end

        if (i_use_imm) begin
            o_op_b = imm_ext;
        end else begin
            o_op_b = rt_fwd;
        end
    end

    assign o_store_data = rt_fwd; // SW writes the bypassed rt

endmodule

`default_nettype wire

// File: hw/ex_mem_reg.sv
`default_nettype none

module ex_mem_reg (
    input  var logic           i_clk,
    input  var logic           i_rst,
    input  var logic           i_stall,
    input  var logic           i_flush,
    input  var ex_pkg::id_ex_t i_id_ex,
    input  var ex_pkg::word_t  i_result,
    input  var ex_pkg::word_t  i_store_data,
    input  var logic           i_zero,       // ALU zero flag
    output ex_pkg::ex_mem_t    o_ex_mem
);

    import ex_pkg::*;

    logic      bubble;
    logic      valid_q;
    logic      reg_write_q;
    logic      mem_read_q;
    logic      mem_write_q;
    logic      branch_taken_q;
    word_t     result_q;
    word_t     store_data_q;
    reg_addr_t dest_q;

    assign bubble = i_flush || !i_id_ex.valid;

    // Control bits, reset over stall over flush
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            valid_q        <= 1'b0;
            reg_write_q    <= 1'b0;
            mem_read_q     <= 1'b0;
            mem_write_q    <= 1'b0;
            branch_taken_q <= 1'b0;
        end else if (!i_stall) begin
            valid_q        <= !bubble;
            reg_write_q    <= !bubble && i_id_ex.reg_write;
            mem_read_q     <= !bubble && i_id_ex.mem_read;
            mem_write_q    <= !bubble && i_id_ex.mem_write;
            branch_taken_q <= !bubble && i_id_ex.branch && i_zero; // Inverted compare
        end
    end

    // Payload follows the stall only
    always_ff @(posedge i_clk) begin
        if (!i_stall) begin
            result_q     <= i_result;
            store_data_q <= i_store_data;
            dest_q       <= i_id_ex.dest;
        end
    end

    always_comb begin
        o_ex_mem.valid        = valid_q;
        o_ex_mem.result       = result_q;
        o_ex_mem.store_data   = store_data_q;
        o_ex_mem.dest         = dest_q;
        o_ex_mem.reg_write    = reg_write_q;
        o_ex_mem.mem_read     = mem_read_q;
        o_ex_mem.mem_write    = mem_write_q;
        o_ex_mem.branch_taken = branch_taken_q;
    end

endmodule

`default_nettype wire

// File: hw/ex_stage.sv
`default_nettype none

module ex_stage (
    input  var logic            i_clk,
    input  var logic            i_rst,
    input  var logic            i_stall,
    input  var logic            i_flush,
    input  var ex_pkg::id_ex_t  i_id_ex,
    input  var ex_pkg::wb_fwd_t i_wb_fwd,
    output ex_pkg::ex_mem_t     o_ex_mem
);

    import ex_pkg::*;

    alu_ctrl_t alu_ctrl;
    logic      use_shamt;
    logic      use_imm;
    logic      zero_ext;
    word_t     op_a;
    word_t     op_b;
    word_t     store_data;
    word_t     alu_result;
    logic      alu_zero;

    alu_control alu_control_i (
        .i_opcode    (i_id_ex.opcode),
        .i_funct     (i_id_ex.funct),
        .o_alu_ctrl  (alu_ctrl),
        .o_use_shamt (use_shamt),
        .o_use_imm   (use_imm),
        .o_zero_ext  (zero_ext)
    );

    ex_operand_sel ex_operand_sel_i (
        .i_id_ex      (i_id_ex),
        .i_use_shamt  (use_shamt),
        .i_use_imm    (use_imm),
        .i_zero_ext   (zero_ext),
        .i_mem_fwd    (o_ex_mem),   // Own output fed back
        .i_wb_fwd     (i_wb_fwd),
        .o_op_a       (op_a),
        .o_op_b       (op_b),
        .o_store_data (store_data)
    );

    alu alu_i (
        .i_a        (op_a),
        .i_b        (op_b),
        .i_alu_ctrl (alu_ctrl),
        .o_result   (alu_result),
        .o_zero     (alu_zero)
    );

    ex_mem_reg ex_mem_reg_i (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_stall      (i_stall),
        .i_flush      (i_flush),
        .i_id_ex      (i_id_ex),
        .i_result     (alu_result),
        .i_store_data (store_data),
        .i_zero       (alu_zero),
        .o_ex_mem     (o_ex_mem)
    );

endmodule

`default_nettype wire

// File: bench/tb_ex_stage.sv
`default_nettype none

module tb_ex_stage;

    timeunit 1ns;
    timeprecision 1ps;

    import ex_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_TESTS    = 5;
    localparam int TEST_BUDGET  = 200; // Cycles allowed per test

    logic    clk;
    logic    rst;
    logic    stall;
    logic    flush;
    id_ex_t  id_ex;
    wb_fwd_t wb_fwd;
    ex_mem_t ex_mem;

    logic [31:0] rand_state;
    int          error_count;
    int          test_errors;
    int          tests_run;
    int          tests_failed;

    ex_stage ex_stage_i (
        .i_clk    (clk),
        .i_rst    (rst),
        .i_stall  (stall),
        .i_flush  (flush),
        .i_id_ex  (id_ex),
        .i_wb_fwd (wb_fwd),
        .o_ex_mem (ex_mem)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223; // LCG step
        return rand_state;
    endfunction

    // Sources stay in r1..r15 and destinations in r16..r31 to keep random ops apart
    function automatic reg_addr_t random_src();
        logic [31:0] r;
        r = next_rand();
        return reg_addr_t'(1 + r % 15);
    endfunction

    function automatic reg_addr_t random_dest();
        logic [31:0] r;
        r = next_rand();
        return reg_addr_t'({1'b1, r[3:0]});
    endfunction

    function automatic id_ex_t make_instr(input opcode_t op, input funct_t fn,
                                          input reg_addr_t rs, input reg_addr_t rt,
                                          input reg_addr_t rd);
        id_ex_t      id;
        logic [31:0] r;
        id         = '0;
        r          = next_rand();
        id.valid   = 1'b1;
        id.opcode  = op;
        id.funct   = fn;
        id.shamt   = r[4:0];
        id.imm     = r[31:16];
        id.rs_val  = next_rand();
        id.rt_val  = next_rand();
        id.rs_addr = rs;
        id.rt_addr = rt;
        id.dest    = rd;
        id.mem_read  = (op == OP_LW);
        id.mem_write = (op == OP_SW);
        id.branch    = (op == OP_BEQ) || (op == OP_BNE);
        id.reg_write = !id.mem_write && !id.branch;
        return id;
    endfunction

    // MIPS semantics of each instruction on the bypassed rs and rt
    function automatic word_t model_result(input id_ex_t id, input word_t rs, input word_t rt);
        word_t sx;
        word_t zx;
        sx = {{16{id.imm[15]}}, id.imm};
        zx = {16'h0000, id.imm};
        case (id.opcode)
            OP_RTYPE: begin
                case (id.funct)
                    FN_SLL:  return rt << id.shamt;
                    FN_SRL:  return rt >> id.shamt;
                    FN_SRA:  return rt >>> id.shamt;
                    FN_SLLV: return rt << rs[4:0];
                    FN_SRLV: return rt >> rs[4:0];
                    FN_SRAV: return rt >>> rs[4:0];
                    FN_SUBU: return rs - rt;
                    FN_AND:  return rs & rt;
                    FN_OR:   return rs | rt;
                    FN_XOR:  return rs ^ rt;
                    FN_NOR:  return ~(rs | rt);
                    FN_SLT:  return (rs < rt) ? 32'sd1 : 32'sd0;
                    default: return rs + rt;
                endcase
            end
            OP_ADDI, OP_ADDIU, OP_LW, OP_SW: return rs + sx;
            OP_SLTI: return (rs < sx) ? 32'sd1 : 32'sd0;
            OP_ANDI: return rs & zx;
            OP_ORI:  return rs | zx;
            OP_XORI: return rs ^ zx;
            OP_LUI:  return {id.imm, 16'h0000};
            OP_BEQ:  return (rs != rt) ? 32'sd1 : 32'sd0; // Zero means taken
            OP_BNE:  return (rs == rt) ? 32'sd1 : 32'sd0;
            default: return rs + rt;
        endcase
    endfunction

    function automatic ex_mem_t expected_entry(input id_ex_t id, input word_t rs,
                                               input word_t rt);
        ex_mem_t exp;
        exp.valid        = 1'b1;
        exp.result       = model_result(id, rs, rt);
        exp.store_data   = rt;
        exp.dest         = id.dest;
        exp.reg_write    = id.reg_write;
        exp.mem_read     = id.mem_read;
        exp.mem_write    = id.mem_write;
        exp.branch_taken = id.branch && (exp.result == '0);
        return exp;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1; // Drive and sample clear of the edge
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("error at %0d ns: %s got %h expected %h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0d ns: %s got %b expected %b", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_entry(input ex_mem_t exp);
        check_bit("valid", ex_mem.valid, exp.valid);
        check_word("result", ex_mem.result, exp.result);
        check_word("store_data", ex_mem.store_data, exp.store_data);
        check_word("dest", word_t'(ex_mem.dest), word_t'(exp.dest));
        check_bit("reg_write", ex_mem.reg_write, exp.reg_write);
        check_bit("mem_read", ex_mem.mem_read, exp.mem_read);
        check_bit("mem_write", ex_mem.mem_write, exp.mem_write);
        check_bit("branch_taken", ex_mem.branch_taken, exp.branch_taken);
    endtask

    task automatic check_bubble();
        check_bit("valid", ex_mem.valid, 1'b0);
        check_bit("reg_write", ex_mem.reg_write, 1'b0);
        check_bit("mem_read", ex_mem.mem_read, 1'b0);
        check_bit("mem_write", ex_mem.mem_write, 1'b0);
        check_bit("branch_taken", ex_mem.branch_taken, 1'b0);
    endtask

    // Present one instruction, check EX/MEM one cycle later
    task automatic issue(input id_ex_t id, input word_t rs, input word_t rt);
        ex_mem_t exp;
        exp   = expected_entry(id, rs, rt);
        id_ex = id;
        next_cycle();
        check_entry(exp);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        error_count += test_errors;
        $display("test %-12s %s, %0d errors", name,
                 (test_errors == 0) ? "passed" : "failed", test_errors);
        test_errors = 0;
    endtask

    task automatic test_reset();
        rst = 1'b1;
        repeat (RESET_CYCLES) next_cycle();
        rst = 1'b0;
        check_bubble(); // Nothing presented yet
        finish_test("reset");
    endtask

    task automatic test_alu_ops();
        funct_t  functs[13];
        opcode_t opcodes[9];
        id_ex_t  id;
        functs  = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_ADDU,
                    FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT};
        opcodes = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
                    OP_LW, OP_SW};
        foreach (functs[i]) begin
            for (int k = 0; k < 4; k++) begin
                id = make_instr(OP_RTYPE, functs[i], random_src(), random_src(), random_dest());
                id.rs_val[31] = k[1]; // Every sign pairing of rs and rt
                id.rt_val[31] = k[0];
                issue(id, id.rs_val, id.rt_val);
            end
        end
        foreach (opcodes[i]) begin
            for (int k = 0; k < 4; k++) begin
                id = make_instr(opcodes[i], FN_SLL, random_src(), random_src(), random_dest());
                id.imm[15]    = k[0]; // Both immediate signs
                id.rs_val[31] = k[1];
                issue(id, id.rs_val, id.rt_val);
            end
        end
        finish_test("alu_ops");
    endtask

    task automatic branch_case(input opcode_t op, input logic equal, input logic taken);
        id_ex_t id;
        id = make_instr(op, FN_SLL, 5'd1, 5'd2, 5'd0);
        if (equal) begin
            id.rt_val = id.rs_val;
        end else begin
            id.rt_val = id.rs_val ^ 32'h0000_0100;
        end
        issue(id, id.rs_val, id.rt_val);
        check_bit("branch_taken", ex_mem.branch_taken, taken);
    endtask

    task automatic test_branches();
        branch_case(OP_BEQ, 1'b1, 1'b1);
        branch_case(OP_BEQ, 1'b0, 1'b0);
        branch_case(OP_BNE, 1'b1, 1'b0);
        branch_case(OP_BNE, 1'b0, 1'b1);
        finish_test("branches");
    endtask

    task automatic test_bypass();
        id_ex_t id;
        word_t  r3_val;
        word_t  r6_val;
        id     = make_instr(OP_RTYPE, FN_ADDU, 5'd1, 5'd2, 5'd3);
        r3_val = id.rs_val + id.rt_val;
        issue(id, id.rs_val, id.rt_val);
        id = make_instr(OP_RTYPE, FN_ADDU, 5'd3, 5'd2, 5'd4); // r3 from EX/MEM
        issue(id, r3_val, id.rt_val);

        wb_fwd.reg_write = 1'b1;
        wb_fwd.dest      = 5'd5;
        wb_fwd.value     = 32'sh0000_0077;
        id     = make_instr(OP_RTYPE, FN_ADDU, 5'd5, 5'd2, 5'd6); // r5 from write-back
        r6_val = wb_fwd.value + id.rt_val;
        issue(id, wb_fwd.value, id.rt_val);

        wb_fwd.dest  = 5'd6;
        wb_fwd.value = 32'sh0000_1234;
        id = make_instr(OP_RTYPE, FN_OR, 5'd6, 5'd1, 5'd7); // EX/MEM beats write-back
        issue(id, r6_val, id.rt_val);

        wb_fwd.dest  = 5'd0;
        wb_fwd.value = 32'sh0000_0555;
        id = make_instr(OP_ADDIU, FN_SLL, 5'd1, 5'd2, 5'd0);
        issue(id, id.rs_val, id.rt_val);
        id = make_instr(OP_RTYPE, FN_ADDU, 5'd0, 5'd0, 5'd8); // r0 stays as decoded
        issue(id, id.rs_val, id.rt_val);

        wb_fwd = '0;
        id = make_instr(OP_LW, FN_SLL, 5'd1, 5'd2, 5'd9);
        issue(id, id.rs_val, id.rt_val);
        id = make_instr(OP_RTYPE, FN_ADDU, 5'd9, 5'd9, 5'd10); // Load data not ready
        issue(id, id.rs_val, id.rt_val);
        finish_test("bypass");
    endtask

    task automatic test_stall_flush();
        id_ex_t  id;
        ex_mem_t held;
        id   = make_instr(OP_RTYPE, FN_ADDU, 5'd1, 5'd2, 5'd11);
        held = expected_entry(id, id.rs_val, id.rt_val);
        issue(id, id.rs_val, id.rt_val);

        id    = make_instr(OP_RTYPE, FN_SUBU, 5'd1, 5'd2, 5'd12);
        id_ex = id;
        stall = 1'b1;
        repeat (3) begin
            next_cycle();
            check_entry(held);
        end
        stall = 1'b0;
        next_cycle();
        check_entry(expected_entry(id, id.rs_val, id.rt_val));

        flush = 1'b1;
        id_ex = make_instr(OP_SW, FN_SLL, 5'd1, 5'd2, 5'd13);
        next_cycle();
        check_bubble();
        flush = 1'b0;

        id       = make_instr(OP_LW, FN_SLL, 5'd1, 5'd2, 5'd14);
        id.valid = 1'b0; // Controls set but not valid
        id_ex    = id;
        next_cycle();
        check_bubble();
        id_ex = '0;
        finish_test("stall_flush");
    endtask

    initial begin
        #((RESET_CYCLES + NUM_TESTS * TEST_BUDGET) * CLK_PERIOD);
        $display("timeout: the tests did not finish within the cycle budget");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        stall        = 1'b0;
        flush        = 1'b0;
        id_ex        = '0;
        wb_fwd       = '0;
        rand_state   = 32'h59ee_2ee2;
        error_count  = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;

        test_reset();
        test_alu_ops();
        test_branches();
        test_bypass();
        test_stall_flush();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (tests_failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: ex_stage.f
hw/ex_pkg.sv
hw/alu.sv
hw/alu_control.sv
hw/ex_operand_sel.sv
hw/ex_mem_reg.sv
hw/ex_stage.sv
bench/tb_ex_stage.sv

// File: run_sim.sh
#!/bin/sh
# Builds tb_ex_stage with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timescale 1ns/1ps --top-module tb_ex_stage \
    -f ex_stage.f -Mdir obj_dir -o tb_ex_stage
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_ex_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q "STATUS: PASS" "$LOG"; then
    echo "no pass line in $LOG"
    exit 1
fi
exit 0
